// File: hw/dcr_pkg.sv
`default_nettype none

package dcr_pkg;

    // unsigned adc word
    localparam int DATA_WIDTH = 12;

    // signed result, one bit wider so any difference fits
    localparam int OUT_WIDTH = DATA_WIDTH + 1;

    // channels behind the shared adc
    localparam int NUM_CH = 4;
    localparam int CH_WIDTH = $clog2(NUM_CH);

    // samples per averaging block, must be a power of two
    localparam int AVG_WINDOW = 16;

    // sum to average shift
    localparam int WIN_SHIFT = $clog2(AVG_WINDOW);

    // block sum never overflows at this width
    localparam int ACC_WIDTH = DATA_WIDTH + WIN_SHIFT;

    // in-block sample counter, wraps at AVG_WINDOW
    localparam int CNT_WIDTH = WIN_SHIFT;

endpackage

`default_nettype wire

// File: hw/adc_channel_demux.sv
`timescale 1ns/1ps
`default_nettype none

module adc_channel_demux (
    input  wire                              adc_clk,
    input  wire                              rst_n,
    input  wire                              stable,
    input  wire                              in_valid,
    input  wire [dcr_pkg::CH_WIDTH-1:0]      in_ch,
    input  wire [dcr_pkg::DATA_WIDTH-1:0]    in_data,
    output logic [dcr_pkg::NUM_CH-1:0]       ch_strobe,
    output logic [dcr_pkg::DATA_WIDTH-1:0]   ch_data
);

    logic [dcr_pkg::NUM_CH-1:0] strobe_next;
    logic                       accept;

    // samples outside a stable period are dropped here
    assign accept = in_valid & stable;

    // one-hot decode of the channel tag
    always_comb begin
        strobe_next = '0;
        if (accept) begin
            strobe_next[in_ch] = 1'b1;
        end
    end

    // strobe register, one cycle after in_valid
    always_ff @(posedge adc_clk or negedge rst_n) begin
        if (!rst_n) begin
            ch_strobe <= '0;
        end else begin
            ch_strobe <= strobe_next;
        end
    end

    // shared sample word for all channels
    // only the strobe tells a channel the word is its own
    always_ff @(posedge adc_clk) begin
        if (accept) begin
            ch_data <= in_data;
        end
    end

endmodule

`default_nettype wire

// File: hw/dc_removal.sv
`timescale 1ns/1ps
`default_nettype none

module dc_removal (
    input  wire                                 adc_clk,
    input  wire                                 rst_n,
    input  wire                                 stable,
    input  wire                                 sample_strobe,
    input  wire [dcr_pkg::DATA_WIDTH-1:0]       data_in,
    output logic signed [dcr_pkg::OUT_WIDTH-1:0] data_out,
    output logic                                res_valid,
    output logic [dcr_pkg::DATA_WIDTH-1:0]      avg,
    output logic                                en
);

    // block accumulator and sample position within the block
    logic [dcr_pkg::ACC_WIDTH-1:0]  acc;
    logic [dcr_pkg::CNT_WIDTH-1:0]  cnt;

    logic [dcr_pkg::ACC_WIDTH-1:0]  sum_next;
    logic                           take;
    logic                           block_done;
    logic signed [dcr_pkg::OUT_WIDTH-1:0] diff;

    // a strobe only counts while the input is stable
    assign take = sample_strobe & stable;

    // running sum including the current sample
    assign sum_next = acc + dcr_pkg::ACC_WIDTH'(data_in);

    // window is a power of two, so the last slot is all ones
    assign block_done = take & (&cnt);

    // both operands zero-extended, result always fits in OUT_WIDTH
    assign diff = $signed({1'b0, data_in}) - $signed({1'b0, avg});

    // accumulator, counter and ready flag
    always_ff @(posedge adc_clk or negedge rst_n) begin
        if (!rst_n) begin
            acc <= '0;
            cnt <= '0;
            en  <= 1'b0;
        end else if (!stable) begin
            acc <= '0;
            cnt <= '0;
            en  <= 1'b0;
        end else if (take) begin
            // counter wraps on its own at the block boundary
            cnt <= cnt + 1'b1;
            if (block_done) begin
                acc <= '0;
                en  <= 1'b1;
            end else begin
                acc <= sum_next;
            end
        end
    end

    // stored offset estimate
    // survives a drop of stable until the next full block
    always_ff @(posedge adc_clk or negedge rst_n) begin
        if (!rst_n) begin
            avg <= '0;
        end else if (block_done) begin
            // rounded down block average
            avg <= sum_next[dcr_pkg::ACC_WIDTH-1:dcr_pkg::WIN_SHIFT];
        end
    end

    // result strobe, one cycle after the sample strobe
    // the closing sample of a block still sees the old avg here
    always_ff @(posedge adc_clk or negedge rst_n) begin
        if (!rst_n) begin
            res_valid <= 1'b0;
        end else begin
            res_valid <= take & en;
        end
    end

    // offset-free sample
    always_ff @(posedge adc_clk) begin
        if (take && en) begin
            data_out <= diff;
        end
    end

endmodule

`default_nettype wire

// File: hw/dc_output_collector.sv
`timescale 1ns/1ps
`default_nettype none

module dc_output_collector (
    input  wire                                                 adc_clk,
    input  wire                                                 rst_n,
    input  wire [dcr_pkg::NUM_CH-1:0]                           res_valid,
    input  wire [dcr_pkg::NUM_CH-1:0][dcr_pkg::OUT_WIDTH-1:0]   res_data,
    input  wire [dcr_pkg::NUM_CH-1:0][dcr_pkg::DATA_WIDTH-1:0]  avg,
    input  wire [dcr_pkg::NUM_CH-1:0]                           en,
    input  wire [dcr_pkg::CH_WIDTH-1:0]                         offset_sel,
    output logic                                                out_valid,
    output logic [dcr_pkg::CH_WIDTH-1:0]                        out_ch,
    output logic signed [dcr_pkg::OUT_WIDTH-1:0]                out_data,
    output logic [dcr_pkg::DATA_WIDTH-1:0]                      offset_out,
    output logic [dcr_pkg::NUM_CH-1:0]                          ready_mask
);

    logic                           any_valid;
    logic [dcr_pkg::CH_WIDTH-1:0]   hit_ch;

    // channels share one latency, so at most one bit is ever set
    assign any_valid = |res_valid;

    // index of the active channel
    always_comb begin
        hit_ch = '0;
        for (int k = 0; k < dcr_pkg::NUM_CH; k++) begin
            if (res_valid[k]) begin
                hit_ch = dcr_pkg::CH_WIDTH'(k);
            end
        end
    end

    // merged output strobe
    always_ff @(posedge adc_clk or negedge rst_n) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= any_valid;
        end
    end

    // tag and result of the active channel
    always_ff @(posedge adc_clk) begin
        if (any_valid) begin
            out_ch   <= hit_ch;
            out_data <= $signed(res_data[hit_ch]);
        end
    end

    // offset readout, one cycle behind offset_sel and avg
    always_ff @(posedge adc_clk or negedge rst_n) begin
        if (!rst_n) begin
            offset_out <= '0;
        end else begin
            offset_out <= avg[offset_sel];
        end
    end

    // ready levels go straight out
    assign ready_mask = en;

endmodule

`default_nettype wire

// File: hw/dcr_frontend_top.sv
`timescale 1ns/1ps
`default_nettype none

module dcr_frontend_top (
    input  wire                                  adc_clk,
    input  wire                                  rst_n,
    input  wire                                  stable,
    input  wire                                  in_valid,
    input  wire [dcr_pkg::CH_WIDTH-1:0]          in_ch,
    input  wire [dcr_pkg::DATA_WIDTH-1:0]        in_data,
    input  wire [dcr_pkg::CH_WIDTH-1:0]          offset_sel,
    output logic                                 out_valid,
    output logic [dcr_pkg::CH_WIDTH-1:0]         out_ch,
    output logic signed [dcr_pkg::OUT_WIDTH-1:0] out_data,
    output logic [dcr_pkg::DATA_WIDTH-1:0]       offset_out,
    output logic [dcr_pkg::NUM_CH-1:0]           ready_mask
);

    // demux to channels
    logic [dcr_pkg::NUM_CH-1:0]                           ch_strobe;
    logic [dcr_pkg::DATA_WIDTH-1:0]                       ch_data;

    // channels to collector
    logic [dcr_pkg::NUM_CH-1:0]                           res_valid;
    logic [dcr_pkg::NUM_CH-1:0][dcr_pkg::OUT_WIDTH-1:0]   res_data;
    logic [dcr_pkg::NUM_CH-1:0][dcr_pkg::DATA_WIDTH-1:0]  avg;
    logic [dcr_pkg::NUM_CH-1:0]                           en;

    adc_channel_demux i_demux (
        .adc_clk   (adc_clk),
        .rst_n     (rst_n),
        .stable    (stable),
        .in_valid  (in_valid),
        .in_ch     (in_ch),
        .in_data   (in_data),
        .ch_strobe (ch_strobe),
        .ch_data   (ch_data)
    );

    // one offset remover per channel
    for (genvar k = 0; k < dcr_pkg::NUM_CH; k++) begin : g_ch
        dc_removal i_dcr (
            .adc_clk       (adc_clk),
            .rst_n         (rst_n),
            .stable        (stable),
            .sample_strobe (ch_strobe[k]),
            .data_in       (ch_data),
            .data_out      (res_data[k]),
            .res_valid     (res_valid[k]),
            .avg           (avg[k]),
            .en            (en[k])
        );
    end

    dc_output_collector i_collector (
        .adc_clk    (adc_clk),
        .rst_n      (rst_n),
        .res_valid  (res_valid),
        .res_data   (res_data),
        .avg        (avg),
        .en         (en),
        .offset_sel (offset_sel),
        .out_valid  (out_valid),
        .out_ch     (out_ch),
        .out_data   (out_data),
        .offset_out (offset_out),
        .ready_mask (ready_mask)
    );

endmodule

`default_nettype wire

// File: sim/tb_dcr_frontend.sv
`timescale 1ns/1ps
`default_nettype none

module tb_dcr_frontend;

    logic                                 adc_clk;
    logic                                 rst_n;
    logic                                 stable;
    logic                                 in_valid;
    logic [dcr_pkg::CH_WIDTH-1:0]         in_ch;
    logic [dcr_pkg::DATA_WIDTH-1:0]       in_data;
    logic [dcr_pkg::CH_WIDTH-1:0]         offset_sel;
    logic                                 out_valid;
    logic [dcr_pkg::CH_WIDTH-1:0]         out_ch;
    logic signed [dcr_pkg::OUT_WIDTH-1:0] out_data;
    logic [dcr_pkg::DATA_WIDTH-1:0]       offset_out;
    logic [dcr_pkg::NUM_CH-1:0]           ready_mask;

    // stimulus table with one row per phase
    // columns are stable level, sample count, order mode and gap percent
    // order 0 is round-robin and 1 is random
    int row_stable [0:4] = '{1, 1, 0, 1, 1};
    int row_len    [0:4] = '{160, 96, 40, 160, 200};
    int row_order  [0:4] = '{0, 0, 1, 1, 1};
    int row_gap    [0:4] = '{0, 25, 0, 30, 0};
    // per channel dc offset and triangle amplitude
    int row_ofs [0:4][0:dcr_pkg::NUM_CH-1] = '{
        '{2048, 1000, 3000, 500},
        '{1500, 2500, 700, 3900},
        '{100, 200, 300, 400},
        '{3500, 600, 2000, 1200},
        '{800, 3000, 4000, 2222}
    };
    int row_amp [0:4][0:dcr_pkg::NUM_CH-1] = '{
        '{64, 200, 31, 500},
        '{10, 300, 77, 1},
        '{50, 50, 50, 50},
        '{128, 33, 250, 400},
        '{7, 600, 90, 256}
    };

    // reference model state per channel
    int mdl_sum [dcr_pkg::NUM_CH];
    int mdl_cnt [dcr_pkg::NUM_CH];
    int mdl_avg [dcr_pkg::NUM_CH];
    int tri_idx [dcr_pkg::NUM_CH];
    logic [dcr_pkg::NUM_CH-1:0] mdl_rdy = '0;

    // sample still in the demux stage
    logic pend_valid = 1'b0;
    int pend_ch = 0;
    int pend_data = 0;
    int pend_due = 0;

    // one-cycle delay lines for the ready and offset readout checks
    logic [dcr_pkg::NUM_CH-1:0] rdy_d1 = '0;
    int avg_h0 [dcr_pkg::NUM_CH];
    int avg_h1 [dcr_pkg::NUM_CH];
    int exp_off = 0;

    // expected results in arrival order
    int q_due [$];
    int q_ch [$];
    int q_data [$];

    int seed = 32'h305ffb07;
    int errors = 0;
    int ncyc = 0;
    int cyc_count = 0;
    int cycle_limit = 0;

    dcr_frontend_top i_dut (
        .adc_clk    (adc_clk),
        .rst_n      (rst_n),
        .stable     (stable),
        .in_valid   (in_valid),
        .in_ch      (in_ch),
        .in_data    (in_data),
        .offset_sel (offset_sel),
        .out_valid  (out_valid),
        .out_ch     (out_ch),
        .out_data   (out_data),
        .offset_out (offset_out),
        .ready_mask (ready_mask)
    );

    initial begin
        adc_clk = 1'b0;
        forever #2 adc_clk = ~adc_clk;
    end

    task automatic check_value(input string name, input int got, input int exp);
        if (got != exp) begin
            $display("MISMATCH at %0t: %s got %0d expected %0d", $time, name, got, exp);
            errors++;
        end
    endtask

    // triangle around zero with period 2*amp
    function automatic int triangle_value(input int n, input int amp);
        int t;
        t = n % (2 * amp);
        if (t < amp) begin
            return t - amp / 2;
        end
        return 2 * amp - t - amp / 2;
    endfunction

    task automatic model_sample(input int ch, input int data, input int due);
        if (mdl_rdy[ch]) begin
            q_due.push_back(due);
            q_ch.push_back(ch);
            q_data.push_back(data - mdl_avg[ch]);
        end
        mdl_sum[ch] += data;
        mdl_cnt[ch]++;
        if (mdl_cnt[ch] == dcr_pkg::AVG_WINDOW) begin
            // sum is never negative, so integer division rounds down
            mdl_avg[ch] = mdl_sum[ch] / dcr_pkg::AVG_WINDOW;
            mdl_sum[ch] = 0;
            mdl_cnt[ch] = 0;
            mdl_rdy[ch] = 1'b1;
        end
    endtask

    task automatic check_outputs();
        if (out_valid) begin
            if (q_due.size() == 0) begin
                $display("%0t: out_valid went high with no result expected", $time);
                errors++;
            end else begin
                check_value("out_valid cycle", ncyc, q_due[0]);
                check_value("out_ch", int'(out_ch), q_ch[0]);
                check_value("out_data", int'(out_data), q_data[0]);
                void'(q_due.pop_front());
                void'(q_ch.pop_front());
                void'(q_data.pop_front());
            end
        end
        if (q_due.size() > 0 && q_due[0] <= ncyc) begin
            $display("%0t: expected result for channel %0d never arrived", $time, q_ch[0]);
            errors++;
            void'(q_due.pop_front());
            void'(q_ch.pop_front());
            void'(q_data.pop_front());
        end
        check_value("ready_mask", int'(ready_mask), int'(rdy_d1));
        check_value("offset_out", int'(offset_out), exp_off);
    endtask

    // check, drive and advance the model on one falling edge
    task automatic tick(input logic st, input logic v, input int ch, input int data);
        logic fell;
        @(negedge adc_clk);
        ncyc++;
        check_outputs();
        fell = stable && !st;
        stable = st;
        in_valid = v;
        in_ch = dcr_pkg::CH_WIDTH'(ch);
        in_data = dcr_pkg::DATA_WIDTH'(data);
        offset_sel = dcr_pkg::CH_WIDTH'(ncyc % dcr_pkg::NUM_CH)
;
        // a channel takes the previous sample under the level driven now
        if (fell) begin
            for (int k = 0; k < dcr_pkg::NUM_CH; k++) begin
                mdl_sum[k] = 0;
                mdl_cnt[k] = 0;
            end
            mdl_rdy = '0;
        end else if (pend_valid) begin
            model_sample(pend_ch, pend_data, pend_due);
        end
        pend_valid = v && st;
        pend_ch = ch;
        pend_data = data;
        pend_due = ncyc + 3;
        rdy_d1 = mdl_rdy;
        avg_h1 = avg_h0;
        avg_h0 = mdl_avg;
        exp_off = avg_h1[ncyc % dcr_pkg::NUM_CH];
    endtask

    task automatic run_phase(input int row);
        int n;
        int ch;
        int data;
        int rr;
        logic st;
        st = (row_stable[row] != 0);
        // switch the stable level right behind the last sample of the previous phase
        repeat (2) tick(st, 1'b0, 0, 0);
        n = 0;
        rr = 0;
        while (n < row_len[row]) begin
            if ($unsigned($random(seed)) % 100 < row_gap[row]) begin
                tick(st, 1'b0, 0, 0);
            end else begin
                if (row_order[row] == 0) begin
                    ch = rr;
                    rr = (rr + 1) % dcr_pkg::NUM_CH;
                end else begin
                    ch = $unsigned($random(seed)) % dcr_pkg::NUM_CH;
                end
                data = row_ofs[row][ch] + triangle_value(tri_idx[ch], row_amp[row][ch]);
                tri_idx[ch]++;
                tick(st, 1'b1, ch, data);
                n++;
            end
        end
    endtask

    // run limit sized from the table
    initial begin
        @(posedge adc_clk);
        while (cyc_count < cycle_limit) begin
            @(posedge adc_clk);
            cyc_count++;
        end
        $display("timeout: the run did not finish within %0d cycles", cycle_limit);
        errors++;
        $display("summary: %0d errors", errors);
        $display("Test FAILED");
        $finish;
    end

    initial begin
        int total;
        total = 0;
        rst_n = 1'b0;
        stable = 1'b0;
        in_valid = 1'b0;
        in_ch = '0;
        in_data = '0;
        offset_sel = '0;
        foreach (row_len[r]) begin
            total += row_len[r];
        end
        cycle_limit = 4 * total + 200;
        repeat (2) @(posedge adc_clk);
        @(negedge adc_clk);
        rst_n = 1'b1;
        for (int r = 0; r < 5; r++) begin
            run_phase(r);
        end
        repeat (8) tick(stable, 1'b0, 0, 0);
        if (q_due.size() != 0) begin
            $display("%0d expected results still pending at the end of the run", q_due.size());
            errors += q_due.size();
        end
        $display("summary: %0d errors over %0d cycles", errors, ncyc);
        if (errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: build.f
hw/dcr_pkg.sv
hw/adc_channel_demux.sv
hw/dc_removal.sv
hw/dc_output_collector.sv
hw/dcr_frontend_top.sv
sim/tb_dcr_frontend.sv

// File: run_sim.sh
#!/bin/sh
# compile and run the DC-removal front end testbench with Verilator

cd "$(dirname "$0")" || exit 1

# build the simulation binary
verilator --binary --timing \
    --top-module tb_dcr_frontend \
    -f build.f \
    -Mdir obj_dir \
    -o sim_tb
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

# run it and keep the output for the verdict
output=$(./obj_dir/sim_tb)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

# pass only if the testbench printed its pass line
if printf '%s\n' "$output" | grep -qx "Test OK"; then
    exit 0
else
    echo "pass line not found in simulation output"
    exit 1
fi
